/* source/mapperPkg.sv */
/* mapper package
   screen and sprite geometry, color types, game states and the palette
   shared by the pixel color mapper pipeline */
package mapperPkg;

	// ------------------------------
	// screen and coordinate sizes
	// ------------------------------
	localparam int COORD_W      = 10;
	localparam int SCREEN_WIDTH = 640;
	localparam int COLOR_IDX_W  = 4;
	localparam int PALETTE_SIZE = 2 ** COLOR_IDX_W;
	localparam int NUM_LAYERS   = 6;
	// gradient comes from DrawX[9:3]
	localparam int GRAD_W       = COORD_W - 3;

	localparam int BG_ADDR_W     = 16;
	localparam int SPRITE_ADDR_W = 16;
	// half resolution background, pixels per row
	localparam int BG_ROW_BYTES  = SCREEN_WIDTH / 2;

	typedef logic [COORD_W-1:0]     coordT;
	typedef logic [COLOR_IDX_W-1:0] colorIdxT;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbT;

	// state value 3 is shown like OVER
	typedef enum logic [1:0] {SELECT = 2'd0, FIGHT = 2'd1, OVER = 2'd2} gameStateT;

	// ascending priority order in FIGHT
	typedef enum logic [2:0] {TANK_A, TANK_B, BULLET_A, BULLET_B, HP_A, HP_B} layerT;

	// ------------------------------
	// sprite windows, inclusive
	// ------------------------------
	localparam int TANK_WIDTH  = 100;
	localparam int TANK_HEIGHT = 80;
	localparam int BULLET_SIZE = 20;
	localparam int HP_WIDTH    = 70;
	localparam int HP_HEIGHT   = 20;

	localparam coordT HP_A_X = 10'd80;
	localparam coordT HP_A_Y = 10'd80;
	localparam coordT HP_B_X = 10'd490;
	localparam coordT HP_B_Y = 10'd80;

	// ------------------------------
	// colors
	// ------------------------------
	localparam rgbT TRANSPARENT_KEY = 24'hB0B0B0;
	localparam rgbT HP_A_COLOR      = 24'h00FF00;
	localparam rgbT HP_B_COLOR      = 24'hFF0000;

	// entry 0 is the key, no pure red or pure green in here
	localparam rgbT PALETTE [PALETTE_SIZE] = '{
		24'hB0B0B0, 24'h000000, 24'hFFFFFF, 24'h3C5A28,
		24'h6E8C3C, 24'h8B5A2B, 24'hC89650, 24'h1E3C78,
		24'h5078C8, 24'hA0C8F0, 24'hC83C3C, 24'hF0C828,
		24'h646464, 24'h3C3C3C, 24'hE6E6D2, 24'h783C8C
	};

endpackage

/* source/layerBuses.sv */
/* pipeline stage buses
   decodeBus carries hits and color indices, colorBus carries looked-up colors */
`timescale 1ns/100ps

// ------------------------------
// decode to execute
// ------------------------------
interface decodeBus import mapperPkg::*; ();

	// one bit and one index per sprite layer, indexed by layerT
	logic      [NUM_LAYERS-1:0] hit;
	colorIdxT  [NUM_LAYERS-1:0] idx;
	colorIdxT                   bgIdx;
	gameStateT                  state;
	logic      [GRAD_W-1:0]     gradient;

	modport producer (output hit, idx, bgIdx, state, gradient);
	modport consumer (input hit, idx, bgIdx, state, gradient);

endinterface

// ------------------------------
// execute to result
// ------------------------------
interface colorBus import mapperPkg::*; ();

	rgbT                        bgRgb;
	rgbT       [NUM_LAYERS-1:0] layerRgb;
	// hit and not the transparent key
	logic      [NUM_LAYERS-1:0] opaque;
	gameStateT                  state;
	logic      [GRAD_W-1:0]     gradient;

	modport producer (output bgRgb, layerRgb, opaque, state, gradient);
	modport consumer (input bgRgb, layerRgb, opaque, state, gradient);

endinterface

/* source/objectWindow.sv */
/* object window
   inclusive rectangle hit test and row-major sprite address for one object */
`timescale 1ns/100ps

module objectWindow import mapperPkg::*; #(
	parameter int WIDTH  = TANK_WIDTH,
	parameter int HEIGHT = TANK_HEIGHT
) (
	input  logic                     VGA_Clk,
	input  coordT                    pixelX,
	input  coordT                    pixelY,
	input  coordT                    originX,
	input  coordT                    originY,
	output logic                     hit,
	output logic [SPRITE_ADDR_W-1:0] addr
);

	// window spans WIDTH+1 by HEIGHT+1 pixels
	localparam int AREA = (WIDTH + 1) * (HEIGHT + 1);

	logic signed [COORD_W:0] offX;
	logic signed [COORD_W:0] offY;

	// offsets go negative left of and above the origin
	assign offX = $signed({1'b0, pixelX}) - $signed({1'b0, originX});
	assign offY = $signed({1'b0, pixelY}) - $signed({1'b0, originY});

	assign hit = (offX >= 0) && (offX <= WIDTH) && (offY >= 0) && (offY <= HEIGHT);

	// meaningless outside the window
	assign addr = SPRITE_ADDR_W'(offY * WIDTH + offX);

	// a hit must land inside the sprite image
	assert property (@(posedge VGA_Clk) hit |-> (addr < AREA))
		else $error("objectWindow: address %0d beyond %0d entry sprite", addr, AREA);

endmodule

/* source/spriteDecoder.sv */
/* decode stage
   background address and nibble select, six sprite windows, and the
   register that hands hits and color indices to the palette stage */
`timescale 1ns/100ps

module spriteDecoder import mapperPkg::*; (
	input  logic                     VGA_Clk,
	input  logic                     Reset,
	input  coordT                    DrawX, DrawY,
	input  coordT                    TankXA, TankYA, TankXB, TankYB,
	input  coordT                    BulletXA, BulletYA, BulletXB, BulletYB,
	input  gameStateT                gameState,
	input  logic [7:0]               bgData,
	input  colorIdxT                 tankIdxA, tankIdxB,
	input  colorIdxT                 bulletIdxA, bulletIdxB,
	input  colorIdxT                 hpIdxA, hpIdxB,
	output logic [BG_ADDR_W-1:0]     bgAddr,
	output logic [SPRITE_ADDR_W-1:0] tankAddrA, tankAddrB,
	output logic [SPRITE_ADDR_W-1:0] bulletAddrA, bulletAddrB,
	output logic [SPRITE_ADDR_W-1:0] hpAddrA, hpAddrB,
	decodeBus.producer               dec
);

	logic [NUM_LAYERS-1:0] hitNow;
	logic [BG_ADDR_W:0]    bgPixel;
	colorIdxT              bgIdxNow;

	// ------------------------------
	// background
	// ------------------------------
	// pixel number in the half resolution image, two per byte
	assign bgPixel  = (BG_ADDR_W + 1)'((DrawY >> 1) * BG_ROW_BYTES + (DrawX >> 1));
	assign bgAddr   = bgPixel[BG_ADDR_W:1];
	// even column sits in the high nibble
	assign bgIdxNow = DrawX[0] ? bgData[3:0] : bgData[7:4];

	// ------------------------------
	// sprite windows
	// ------------------------------
	objectWindow #(.WIDTH(TANK_WIDTH), .HEIGHT(TANK_HEIGHT)) tankWinA (
		.VGA_Clk(VGA_Clk), .pixelX(DrawX), .pixelY(DrawY),
		.originX(TankXA), .originY(TankYA), .hit(hitNow[TANK_A]), .addr(tankAddrA)
	);
	objectWindow #(.WIDTH(TANK_WIDTH), .HEIGHT(TANK_HEIGHT)) tankWinB (
		.VGA_Clk(VGA_Clk), .pixelX(DrawX), .pixelY(DrawY),
		.originX(TankXB), .originY(TankYB), .hit(hitNow[TANK_B]), .addr(tankAddrB)
	);
	objectWindow #(.WIDTH(BULLET_SIZE), .HEIGHT(BULLET_SIZE)) bulletWinA (
		.VGA_Clk(VGA_Clk), .pixelX(DrawX), .pixelY(DrawY),
		.originX(BulletXA), .originY(BulletYA), .hit(hitNow[BULLET_A]), .addr(bulletAddrA)
	);
	objectWindow #(.WIDTH(BULLET_SIZE), .HEIGHT(BULLET_SIZE)) bulletWinB (
		.VGA_Clk(VGA_Clk), .pixelX(DrawX), .pixelY(DrawY),
		.originX(BulletXB), .originY(BulletYB), .hit(hitNow[BULLET_B]), .addr(bulletAddrB)
	);
	// HP bars sit at fixed spots
	objectWindow #(.WIDTH(HP_WIDTH), .HEIGHT(HP_HEIGHT)) hpWinA (
		.VGA_Clk(VGA_Clk), .pixelX(DrawX), .pixelY(DrawY),
		.originX(HP_A_X), .originY(HP_A_Y), .hit(hitNow[HP_A]), .addr(hpAddrA)
	);
	objectWindow #(.WIDTH(HP_WIDTH), .HEIGHT(HP_HEIGHT)) hpWinB (
		.VGA_Clk(VGA_Clk), .pixelX(DrawX), .pixelY(DrawY),
		.originX(HP_B_X), .originY(HP_B_Y), .hit(hitNow[HP_B]), .addr(hpAddrB)
	);

	// ------------------------------
	// pipeline register
	// ------------------------------
	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset) begin
			dec.hit   <= '0;
			dec.state <= SELECT;
		end else begin
			dec.hit   <= hitNow;
			dec.state <= gameState;
		end
	end

	// ROM data for this pixel
	always_ff @(posedge VGA_Clk) begin
		dec.bgIdx         <= bgIdxNow;
		dec.idx[TANK_A]   <= tankIdxA;
		dec.idx[TANK_B]   <= tankIdxB;
		dec.idx[BULLET_A] <= bulletIdxA;
		dec.idx[BULLET_B] <= bulletIdxB;
		dec.idx[HP_A]     <= hpIdxA;
		dec.idx[HP_B]     <= hpIdxB;
		dec.gradient      <= DrawX[COORD_W-1 -: GRAD_W];
	end

endmodule

/* source/paletteLookup.sv */
/* execute stage
   palette lookup for the background and every sprite layer, with opacity flags */
`timescale 1ns/100ps

module paletteLookup import mapperPkg::*; (
	decodeBus.consumer dec,
	colorBus.producer  col
);

	// ------------------------------
	// palette helpers
	// ------------------------------
	function automatic rgbT lookUp(colorIdxT idx);
		return PALETTE[idx];
	endfunction

	// key colored pixels let the layer below show through
	function automatic logic isOpaque(logic hit, colorIdxT idx);
		return hit && (lookUp(idx) != TRANSPARENT_KEY);
	endfunction

	// ------------------------------
	// background
	// ------------------------------
	assign col.bgRgb = lookUp(dec.bgIdx);

	// ------------------------------
	// sprite layers
	// ------------------------------
	always_comb begin
		for (int i = 0; i < NUM_LAYERS; i++) begin
			col.layerRgb[i] = lookUp(dec.idx[i]);
			col.opaque[i]   = isOpaque(dec.hit[i], dec.idx[i]);
		end
	end

	// state and gradient ride along unchanged
	assign col.state    = dec.state;
	assign col.gradient = dec.gradient;

endmodule

/* source/pixelCompositor.sv */
/* result stage
   stacks the layers by game state priority and registers the RGB output */
`timescale 1ns/100ps

module pixelCompositor import mapperPkg::*; (
	input  logic       VGA_Clk,
	input  logic       Reset,
	colorBus.consumer  col,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue
);

	rgbT  pixelNext;
	rgbT  pixelOut;

	function automatic logic isHpColor(rgbT c);
		return (c == HP_A_COLOR) || (c == HP_B_COLOR);
	endfunction

	// ------------------------------
	// layer priority
	// ------------------------------
	always_comb begin
		pixelNext = col.bgRgb;
		case (col.state)
			SELECT: begin
				// tank B drawn over tank A
				if (col.opaque[TANK_A])
					pixelNext = col.layerRgb[TANK_A];
				if (col.opaque[TANK_B])
					pixelNext = col.layerRgb[TANK_B];
			end
			FIGHT: begin
				// tanks, then bullets, lowest priority first
				for (int i = TANK_A; i <= BULLET_B; i++) begin
					if (col.opaque[i])
						pixelNext = col.layerRgb[i];
				end
				// HP bars draw in solid team colors
				if (col.opaque[HP_A])
					pixelNext = HP_A_COLOR;
				if (col.opaque[HP_B])
					pixelNext = HP_B_COLOR;
			end
			default: begin
				// game over, green fades across the screen
				pixelNext.red   = 8'h00;
				pixelNext.green = 8'hFF - 8'(col.gradient);
				pixelNext.blue  = 8'hFF;
			end
		endcase
	end

	// ------------------------------
	// output register
	// ------------------------------
	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset)
			pixelOut <= '0;
		else
			pixelOut <= pixelNext;
	end

	assign Red   = pixelOut.red;
	assign Green = pixelOut.green;
	assign Blue  = pixelOut.blue;

	// HP bars stay hidden while tanks are picked, palette holds no bar color
	assert property (@(posedge VGA_Clk) disable iff (Reset)
		(col.state == SELECT) |=> !isHpColor(pixelOut))
		else $error("pixelCompositor: HP bar color %06h shown in SELECT", pixelOut);

endmodule

/* source/colorMapper.sv */
/* pixel color mapper top
   three stage pipeline from pixel coordinate to 24-bit color for the tank game */
`timescale 1ns/100ps

module colorMapper import mapperPkg::*; (
	input  logic                     VGA_Clk,
	input  logic                     Reset,
	input  coordT                    DrawX, DrawY,
	input  coordT                    TankXA, TankYA, TankXB, TankYB,
	input  coordT                    BulletXA, BulletYA, BulletXB, BulletYB,
	input  gameStateT                gameState,
	input  logic [7:0]               bgData,
	input  colorIdxT                 tankIdxA, tankIdxB,
	input  colorIdxT                 bulletIdxA, bulletIdxB,
	input  colorIdxT                 hpIdxA, hpIdxB,
	output logic [BG_ADDR_W-1:0]     bgAddr,
	output logic [SPRITE_ADDR_W-1:0] tankAddrA, tankAddrB,
	output logic [SPRITE_ADDR_W-1:0] bulletAddrA, bulletAddrB,
	output logic [SPRITE_ADDR_W-1:0] hpAddrA, hpAddrB,
	output logic [7:0]               Red, Green, Blue
);

	decodeBus decBus ();
	colorBus  colBus ();

	// ------------------------------
	// decode, addresses out and indices back
	// ------------------------------
	spriteDecoder decodeStage (
		.VGA_Clk    (VGA_Clk),    .Reset      (Reset),
		.DrawX      (DrawX),      .DrawY      (DrawY),
		.TankXA     (TankXA),     .TankYA     (TankYA),
		.TankXB     (TankXB),     .TankYB     (TankYB),
		.BulletXA   (BulletXA),   .BulletYA   (BulletYA),
		.BulletXB   (BulletXB),   .BulletYB   (BulletYB),
		.gameState  (gameState),  .bgData     (bgData),
		.tankIdxA   (tankIdxA),   .tankIdxB   (tankIdxB),
		.bulletIdxA (bulletIdxA), .bulletIdxB (bulletIdxB),
		.hpIdxA     (hpIdxA),     .hpIdxB     (hpIdxB),
		.bgAddr     (bgAddr),
		.tankAddrA  (tankAddrA),  .tankAddrB  (tankAddrB),
		.bulletAddrA(bulletAddrA), .bulletAddrB(bulletAddrB),
		.hpAddrA    (hpAddrA),    .hpAddrB    (hpAddrB),
		.dec        (decBus)
	);

	// execute, palette colors
	paletteLookup executeStage (
		.dec(decBus),
		.col(colBus)
	);

	// result, registered RGB
	pixelCompositor resultStage (
		.VGA_Clk(VGA_Clk),
		.Reset  (Reset),
		.col    (colBus),
		.Red    (Red),
		.Green  (Green),
		.Blue   (Blue)
	);

endmodule

/* include/tbRefModel.svh */
/* testbench reference model
   LFSR step, sprite ROM stand-ins and the expected color of one pixel */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

	// window sizes per layer, indexed like layerT
	localparam int WIN_W [NUM_LAYERS] = '{TANK_WIDTH, TANK_WIDTH, BULLET_SIZE, BULLET_SIZE,
		HP_WIDTH, HP_WIDTH};
	localparam int WIN_H [NUM_LAYERS] = '{TANK_HEIGHT, TANK_HEIGHT, BULLET_SIZE, BULLET_SIZE,
		HP_HEIGHT, HP_HEIGHT};

	// one Fibonacci step, feedback enters at bit 0
	function automatic logic [15:0] lfsrNext(logic [15:0] s);
		return {s[14:0], ^(s & LFSR_TAPS)};
	endfunction

	// sprite ROM stand-in, address nibbles folded together
	function automatic colorIdxT romIdx(logic [SPRITE_ADDR_W-1:0] a, colorIdxT salt);
		return a[3:0] ^ a[7:4] ^ a[11:8] ^ a[15:12] ^ salt;
	endfunction

	// inclusive at both edges
	function automatic logic winHit(coordT px, coordT py, coordT ox, coordT oy, int w, int h);
		int dx;
		int dy;
		dx = int'(px) - int'(ox);
		dy = int'(py) - int'(oy);
		return (dx >= 0) && (dx <= w) && (dy >= 0) && (dy <= h);
	endfunction

	function automatic logic [SPRITE_ADDR_W-1:0] winAddr(coordT px, coordT py, coordT ox,
		coordT oy, int w);
		return SPRITE_ADDR_W'((int'(py) - int'(oy)) * w + int'(px) - int'(ox));
	endfunction

	// half resolution image, two pixels per byte
	function automatic logic [BG_ADDR_W-1:0] refBgAddr(coordT x, coordT y);
		return BG_ADDR_W'(((int'(y) / 2) * BG_ROW_BYTES + int'(x) / 2) / 2);
	endfunction

	function automatic rgbT refPixel(coordT x, coordT y, coordT ox [NUM_LAYERS],
		coordT oy [NUM_LAYERS], logic [1:0] state, logic [7:0] bg);
		rgbT      c;
		rgbT      layerRgb;
		colorIdxT idx;
		idx = x[0] ? bg[3:0] : bg[7:4];
		c   = PALETTE[idx];
		// OVER and the unused code 3
		if (state[1])
			return '{8'h00, 8'hFF - 8'(x / 8), 8'hFF};
		for (int i = 0; i < NUM_LAYERS; i++) begin
			idx      = romIdx(winAddr(x, y, ox[i], oy[i], WIN_W[i]), colorIdxT'(i));
			layerRgb = PALETTE[idx];
			// SELECT only draws the two tanks
			if ((state == 2'd1 || i <= int'(TANK_B)) && layerRgb != TRANSPARENT_KEY
				&& winHit(x, y, ox[i], oy[i], WIN_W[i], WIN_H[i]))
				c = (i == int'(HP_A)) ? HP_A_COLOR : (i == int'(HP_B)) ? HP_B_COLOR : layerRgb;
		end
		return c;
	endfunction

`endif

/* sim/colorMapperTb.sv */
/* testbench for the pixel color mapper
   random pixels through the pipeline, checked against a reference model */
`timescale 1ns/100ps

module colorMapperTb import mapperPkg::*; ();

	localparam logic [15:0] LFSR_SEED = 16'd16652;
	// x^16 + x^14 + x^13 + x^11 + 1
	localparam logic [15:0] LFSR_TAPS = 16'hB400;
	localparam int NUM_PIXELS    = 3000;
	localparam int DRAIN_TIMEOUT = 20;

	logic                     VGA_Clk;
	logic                     Reset;
	coordT                    DrawX, DrawY;
	coordT                    objX [NUM_LAYERS];
	coordT                    objY [NUM_LAYERS];
	gameStateT                gameState;
	logic [7:0]               bgData;
	logic [BG_ADDR_W-1:0]     bgAddr;
	logic [SPRITE_ADDR_W-1:0] spriteAddr [NUM_LAYERS];
	colorIdxT                 romOut [NUM_LAYERS];
	logic [7:0]               Red, Green, Blue;
	logic [15:0]              lfsrState;
	rgbT                      expQueue [$];
	string                    addrNames [NUM_LAYERS];
	int                       checked;

	`include "tbRefModel.svh"

	always #20 VGA_Clk = ~VGA_Clk;

	colorMapper UUT (
		.VGA_Clk(VGA_Clk), .Reset(Reset), .DrawX(DrawX), .DrawY(DrawY),
		.TankXA(objX[TANK_A]), .TankYA(objY[TANK_A]), .TankXB(objX[TANK_B]), .TankYB(objY[TANK_B]),
		.BulletXA(objX[BULLET_A]), .BulletYA(objY[BULLET_A]),
		.BulletXB(objX[BULLET_B]), .BulletYB(objY[BULLET_B]),
		.gameState(gameState), .bgData(bgData),
		.tankIdxA(romOut[TANK_A]), .tankIdxB(romOut[TANK_B]),
		.bulletIdxA(romOut[BULLET_A]), .bulletIdxB(romOut[BULLET_B]),
		.hpIdxA(romOut[HP_A]), .hpIdxB(romOut[HP_B]), .bgAddr(bgAddr),
		.tankAddrA(spriteAddr[TANK_A]), .tankAddrB(spriteAddr[TANK_B]),
		.bulletAddrA(spriteAddr[BULLET_A]), .bulletAddrB(spriteAddr[BULLET_B]),
		.hpAddrA(spriteAddr[HP_A]), .hpAddrB(spriteAddr[HP_B]),
		.Red(Red), .Green(Green), .Blue(Blue)
	);

	// sprite ROMs answer in the same cycle
	always_comb begin
		for (int i = 0; i < NUM_LAYERS; i++)
			romOut[i] = romIdx(spriteAddr[i], colorIdxT'(i));
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic int unsigned takeBits(int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | lfsrState[0];
		end
		return v;
	endfunction

	task automatic abortRun(string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic checkRgb(string name, rgbT got, rgbT exp);
		if (got !== exp)
			abortRun($sformatf("error: %s = 0x%06h, expected 0x%06h", name, got, exp));
	endtask

	task automatic checkAddr(string name, logic [SPRITE_ADDR_W-1:0] got,
		logic [SPRITE_ADDR_W-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("error: %s = 0x%04h, expected 0x%04h", name, got, exp));
	endtask

	// idle pixel maps to palette entry 1, black, with every window far away
	task automatic setIdle();
		DrawX = '0;
		DrawY = '0;
		for (int i = 0; i < NUM_LAYERS; i++) begin
			objX[i] = 10'd1000;
			objY[i] = 10'd1000;
		end
		{objX[HP_A], objY[HP_A], objX[HP_B], objY[HP_B]} = {HP_A_X, HP_A_Y, HP_B_X, HP_B_Y};
		gameState = SELECT;
		bgData    = 8'h11;
	endtask

	task automatic drivePixel();
		int unsigned r;
		if (takeBits(3) == 0) begin
			// aim at one of the HP bars, a few pixels of margin
			r     = takeBits(1) ? HP_B_X : HP_A_X;
			DrawX = coordT'(r + takeBits(7) % 76 - 3);
			DrawY = coordT'(HP_A_Y + takeBits(5) % 26 - 3);
		end else begin
			DrawX = coordT'(takeBits(10) % SCREEN_WIDTH);
			// 480 visible lines
			DrawY = coordT'(takeBits(9) % 480);
		end
		for (int i = TANK_A; i <= BULLET_B; i++) begin
			if (takeBits(2) != 0) begin
				// origin up to a few pixels past the far edge
				objX[i] = coordT'(DrawX - takeBits(7) % (WIN_W[i] + 6));
				objY[i] = coordT'(DrawY - takeBits(7) % (WIN_H[i] + 6));
			end else begin
				objX[i] = coordT'(takeBits(10));
				objY[i] = coordT'(takeBits(10));
			end
		end
		gameState = gameStateT'(takeBits(2));
		bgData    = 8'(takeBits(8));
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (checked < NUM_PIXELS + 2) begin
			@(negedge VGA_Clk);
			cycles++;
			if (cycles > DRAIN_TIMEOUT)
				abortRun("timeout: the last pixels never reached the RGB outputs");
		end
	endtask

	// ------------------------------
	// compare, one pixel per edge
	// ------------------------------
	always @(posedge VGA_Clk) begin
		rgbT got;
		#1;
		got = {Red, Green, Blue};
		if (Reset) begin
			checkRgb("{Red,Green,Blue}", got, '0);
		end else begin
			expQueue.push_back(refPixel(DrawX, DrawY, objX, objY, gameState, bgData));
			checkRgb("{Red,Green,Blue}", got, expQueue.pop_front());
			checkAddr("bgAddr", bgAddr, refBgAddr(DrawX, DrawY));
			for (int i = 0; i < NUM_LAYERS; i++) begin
				if (winHit(DrawX, DrawY, objX[i], objY[i], WIN_W[i], WIN_H[i]))
					checkAddr(addrNames[i], spriteAddr[i],
						winAddr(DrawX, DrawY, objX[i], objY[i], WIN_W[i]));
			end
			checked++;
		end
	end

	initial begin
		addrNames = '{"tankAddrA", "tankAddrB", "bulletAddrA", "bulletAddrB",
			"hpAddrA", "hpAddrB"};
		VGA_Clk   = 1'b0;
		Reset     = 1'b1;
		lfsrState = LFSR_SEED;
		checked   = 0;
		setIdle();
		// output register is cleared, nothing in flight yet
		expQueue.push_back('0);
		repeat (4) @(negedge VGA_Clk);
		Reset = 1'b0;
		for (int n = 0; n < NUM_PIXELS; n++) begin
			@(negedge VGA_Clk);
			drivePixel();
		end
		waitDrained();
		$display("TEST OK");
		$finish;
	end

endmodule

/* build.f */
+incdir+include
source/mapperPkg.sv
source/layerBuses.sv
source/objectWindow.sv
source/spriteDecoder.sv
source/paletteLookup.sv
source/pixelCompositor.sv
source/colorMapper.sv
sim/colorMapperTb.sv

/* Bender.yml */
package:
  name: color_mapper

sources:
  # RTL in compile order
  - files:
      - source/mapperPkg.sv
      - source/layerBuses.sv
      - source/objectWindow.sv
      - source/spriteDecoder.sv
      - source/paletteLookup.sv
      - source/pixelCompositor.sv
      - source/colorMapper.sv

  # testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/colorMapperTb.sv
